/* Bender.yml */
package:
  name: patch_row_reducer

sources:
  - verilog/patch_pkg.sv
  - verilog/match_if.sv
  - verilog/row_match_fsm.sv
  - verilog/patch_counter.sv
  - verilog/lane_fifo.sv
  - verilog/weighted_accumulator.sv
  - verilog/patch_row_reducer.sv
  - target: test
    files:
      - verif/patch_row_reducer_tb.sv

/* flist.f */
verilog/patch_pkg.sv
verilog/match_if.sv
verilog/row_match_fsm.sv
verilog/patch_counter.sv
verilog/lane_fifo.sv
verilog/weighted_accumulator.sv
verilog/patch_row_reducer.sv
verif/patch_row_reducer_tb.sv

/* verif/patch_row_reducer_tb.sv */
module patch_row_reducer_tb
  import patch_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int PATCH_SIZE     = 6;
  localparam int APP_DATA_WIDTH = 256;
  localparam int SUM_W          = $clog2(PATCH_SIZE) + PIXEL_SIZE + WEIGHT_SIZE;
  localparam int N_TESTS        = 6;
  localparam int N_BEATS        = 4;  // beats sent per test
  localparam int RDY_TIMEOUT    = 40;
  localparam int WATCHDOG_CYC   = N_TESTS * (PATCH_SIZE + 20) * 2;

  typedef struct packed {
    col_t                      start_col;
    logic                      b_top;
    logic [PATCH_SIZE-1:0][11:0] dark;    // column 5 leftmost in literals
    logic [PATCH_SIZE-1:0][15:0] weight;
    col_t                      first_rcol;
    logic [N_BEATS-1:0]        four_lane;  // bit b set for a four-lane beat b
  } test_row_t;

  // reset is the clock port, cl_clk the async active-high reset
  logic                      reset;
  logic                      cl_clk;
  logic                      init;
  logic [APP_DATA_WIDTH-1:0] config_data;
  logic                      sum_ack;
  logic                      pixel012_valid;
  logic                      pixel3_valid;
  col_t                      r_col;
  logic [47:0]               pixel_top;
  logic [47:0]               pixel_btm;
  logic                      sum_rdy;
  logic [SUM_W-1:0]          sum;

  test_row_t   rows     [N_TESTS];
  string       row_name [N_TESTS];
  logic [47:0] beat_top [N_BEATS];
  logic [47:0] beat_btm [N_BEATS];
  col_t        beat_rcol[N_BEATS];
  int          test_errors;
  int          check_errors;
  int          tests_run;
  int          tests_failed;

  patch_row_reducer dut0 (
    .reset, .cl_clk, .init, .config_data, .sum_ack,
    .pixel012_valid, .pixel3_valid, .r_col, .pixel_top, .pixel_btm,
    .sum_rdy, .sum
  );

  initial begin
    reset = 1'b0;
    forever #5 reset = ~reset;
  end

  initial begin
    repeat (WATCHDOG_CYC) @(posedge reset);
    $display("timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYC);
    $display("Something failed");
    $finish;
  end

  task automatic fill_table();
    row_name[0] = "four-lane beats, start on lane 0";
    rows[0] = '{12'd20, 1'b1,
                {12'h030, 12'h025, 12'h020, 12'h015, 12'h010, 12'h005},
                {16'd6, 16'd5, 16'd4, 16'd3, 16'd2, 16'd1}, 12'd23, 4'b1111};
    row_name[1] = "mid-beat start, mixed beats";
    rows[1] = '{12'd33, 1'b1,
                {12'h100, 12'h0f0, 12'h0e0, 12'h0d0, 12'h0c0, 12'h0b0},
                {16'h0102, 16'h0304, 16'h0506, 16'h0708, 16'h090a, 16'h0b0c},
                12'd31, 4'b1010};
    row_name[2] = "bottom row";
    rows[2] = '{12'd100, 1'b0,
                {12'h001, 12'h002, 12'h003, 12'h004, 12'h005, 12'h006},
                {16'h1111, 16'h2222, 16'h3333, 16'h4444, 16'h5555, 16'h6666},
                12'd102, 4'b1100};
    row_name[3] = "top row, start on lane 2";
    rows[3] = '{12'd200, 1'b1,
                {12'h040, 12'h030, 12'h020, 12'h010, 12'h000, 12'h050},
                {16'h00ff, 16'h0fff, 16'h0001, 16'h8000, 16'h0042, 16'h0777},
                12'd201, 4'b1111};
    row_name[4] = "dark above pixel wraps";
    rows[4] = '{12'd300, 1'b0,
                {12'hfff, 12'habc, 12'hfff, 12'h800, 12'hfff, 12'hfff},
                {16'hffff, 16'h1234, 16'h8000, 16'h0001, 16'h00ff, 16'h7fff},
                12'd303, 4'b1111};
    row_name[5] = "zero weights";
    rows[5] = '{12'd50, 1'b1,
                {12'h123, 12'h456, 12'h789, 12'habc, 12'hdef, 12'h321},
                '0, 12'd52, 4'b0000};
  endtask

  function automatic logic [APP_DATA_WIDTH-1:0] pack_config(input test_row_t row);
    logic [APP_DATA_WIDTH-1:0] cfg;
    int                        base;
    cfg       = '0;
    cfg[0]    = row.b_top;
    cfg[12:1] = row.start_col;
    for (int c = 0; c < PATCH_SIZE; c++) begin
      base = 13 + c * 28;  // weight low, dark high
      cfg[base +: 16]      = row.weight[c];
      cfg[base + 16 +: 12] = row.dark[c];
    end
    return cfg;
  endfunction

  // walks the beats column by column from start_col on
  function automatic longint unsigned model_sum(input test_row_t row);
    longint unsigned acc;
    logic [47:0]     data;
    logic [11:0]     p;
    logic [11:0]     diff;
    int              n;
    int              col;
    int              k;
    acc = 0;
    k   = 0;
    for (int b = 0; b < N_BEATS; b++) begin
      n    = row.four_lane[b] ? 4 : 3;
      data = row.b_top ? beat_top[b] : beat_btm[b];
      for (int i = 0; i < n; i++) begin
        col = int'(beat_rcol[b]) - (n - 1) + i;
        if ((col >= int'(row.start_col)) && (k < PATCH_SIZE)) begin
          p    = data[47 - 12*i -: 12];
          diff = p - row.dark[k];  // modulo 4096
          acc  = acc + diff * row.weight[k];
          k++;
        end
      end
    end
    return acc;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      test_errors++;
      check_errors++;
    end
  endtask

  task automatic send_beats(input test_row_t row);
    col_t rc;
    rc = row.first_rcol;
    for (int b = 0; b < N_BEATS; b++) begin
      if (b > 0) begin
        rc = rc + (row.four_lane[b] ? col_t'(4) : col_t'(3));  // contiguous columns
      end
      beat_rcol[b] = rc;
      beat_top[b]  = {16'($urandom()), $urandom()};
      beat_btm[b]  = {16'($urandom()), $urandom()};
      @(posedge reset);
      pixel012_valid <= 1'b1;
      pixel3_valid   <= row.four_lane[b];
      r_col          <= rc;
      pixel_top      <= beat_top[b];
      pixel_btm      <= beat_btm[b];
      @(posedge reset);
      pixel012_valid <= 1'b0;
      pixel3_valid   <= 1'b0;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors != 0) begin
      tests_failed++;
    end
    $display("test %0d %s: %s", tests_run, name, (test_errors == 0) ? "pass" : "FAIL");
  endtask

  task automatic run_row(input int idx);
    test_row_t        row;
    logic [SUM_W-1:0] exp;
    int               wait_n;
    row         = rows[idx];
    test_errors = 0;
    @(posedge reset);
    init        <= 1'b1;
    config_data <= pack_config(row);
    @(posedge reset);
    init <= 1'b0;
    @(posedge reset);
    check_value("sum", sum, '0);  // cleared by init
    check_value("sum_rdy", sum_rdy, 1'b0);
    send_beats(row);
    exp    = SUM_W'(model_sum(row));
    wait_n = 0;
    while (!sum_rdy && (wait_n < RDY_TIMEOUT)) begin
      @(posedge reset);
      wait_n++;
    end
    assert (sum_rdy) else begin
      $display("sum_rdy did not rise within %0d cycles after the last beat", RDY_TIMEOUT);
      test_errors++;
      check_errors++;
    end
    check_value("sum", sum, exp);
    repeat (3) begin
      @(posedge reset);
      check_value("sum_rdy", sum_rdy, 1'b1);  // held until ack
      check_value("sum", sum, exp);
    end
    @(posedge reset);
    sum_ack <= 1'b1;
    @(posedge reset);
    sum_ack <= 1'b0;
    @(posedge reset);
    check_value("sum_rdy", sum_rdy, 1'b0);
    finish_test(row_name[idx]);
  endtask

  initial begin
    cl_clk         = 1'b1;
    init           = 1'b0;
    config_data    = '0;
    sum_ack        = 1'b0;
    pixel012_valid = 1'b0;
    pixel3_valid   = 1'b0;
    r_col          = '0;
    pixel_top      = '0;
    pixel_btm      = '0;
    check_errors   = 0;
    tests_run      = 0;
    tests_failed   = 0;
    void'($urandom(32'hb703));
    fill_table();
    repeat (2) @(posedge reset);
    cl_clk <= 1'b0;

    // no init yet, so no result
    test_errors = 0;
    repeat (10) begin
      @(posedge reset);
      check_value("sum_rdy", sum_rdy, 1'b0);
    end
    finish_test("idle after reset");

    for (int t = 0; t < N_TESTS; t++) begin
      run_row(t);
    end

    $display("tests run %0d, tests failed %0d, failed checks %0d",
             tests_run, tests_failed, check_errors);
    if (check_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* verilog/lane_fifo.sv */
module lane_fifo
  import patch_pkg::*;
#(
  parameter int FIFO_DEPTH = 4
) (
  input  logic   reset,
  input  logic   cl_clk,
  match_if.dst   mq,
  output logic   pix_strobe,
  output logic   pix_valid,
  output pixel_t pix
);

  localparam int PTR_W  = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W  = $clog2(FIFO_DEPTH + 1);
  localparam int LANE_W = $clog2(N_LANES);

  logic [N_LANES-1:0]   mem_valid [FIFO_DEPTH];
  pixel_t [N_LANES-1:0] mem_pix   [FIFO_DEPTH];
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     rd_ptr;
  logic [CNT_W-1:0]     count;
  logic [LANE_W-1:0]    lane_idx;  // lane of the head beat sent next
  logic                 empty;
  logic                 push;
  logic                 pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign empty   = (count == '0);
  assign mq.full = (count == CNT_W'(FIFO_DEPTH));
  assign push    = mq.wr_en && !mq.full;
  assign pop     = !empty && (lane_idx == LANE_W'(N_LANES - 1));  // head done after lane 3

  always_ff @(posedge reset or posedge cl_clk) begin
    if (cl_clk) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      lane_idx   <= '0;
      pix_strobe <= 1'b0;
      pix_valid  <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      count <= count + CNT_W'(push) - CNT_W'(pop);
      if (!empty) begin
        lane_idx <= pop ? '0 : lane_idx + 1'b1;
      end
      pix_strobe <= !empty;  // every lane takes a cycle, valid or not
      pix_valid  <= !empty && mem_valid[rd_ptr][lane_idx];
    end
  end

  always_ff @(posedge reset) begin
    if (push) begin
      mem_valid[wr_ptr] <= mq.lane_valid;
      mem_pix[wr_ptr]   <= mq.lane_pixel;
    end
    if (!empty) begin
      pix <= mem_pix[rd_ptr][lane_idx];
    end
  end

  // no back-pressure to the camera, so the beat rate must keep this true
  a_no_overflow: assert property (@(posedge reset) disable iff (cl_clk)
    mq.wr_en |-> !mq.full)
    else $error("lane_fifo: beat written while full");

endmodule

/* verilog/match_if.sv */
interface match_if
  import patch_pkg::*;
();

  logic                       wr_en;       // one beat per high cycle
  logic [N_LANES-1:0]         lane_valid;
  pixel_t [N_LANES-1:0]       lane_pixel;  // lane 0 is the leftmost column
  logic                       full;

  modport src (
    output wr_en,
    output lane_valid,
    output lane_pixel,
    input  full
  );

  modport dst (
    input  wr_en,
    input  lane_valid,
    input  lane_pixel,
    output full
  );

endinterface

/* verilog/patch_counter.sv */
module patch_counter #(
  parameter int PATCH_SIZE = 6
) (
  input  logic                            reset,
  input  logic                            cl_clk,
  input  logic                            load,
  input  logic [2:0]                      dec,
  output logic [$clog2(PATCH_SIZE+1)-1:0] remaining
);

  localparam int CNT_W = $clog2(PATCH_SIZE + 1);

  logic [CNT_W:0] dec_ext;  // one bit wider so a large dec still compares right

  assign dec_ext = (CNT_W + 1)'(dec);

  always_ff @(posedge reset or posedge cl_clk) begin
    if (cl_clk) begin
      remaining <= '0;
    end else if (load) begin
      remaining <= CNT_W'(PATCH_SIZE);
    end else if (dec_ext >= {1'b0, remaining}) begin
      remaining <= '0;  // saturate
    end else begin
      remaining <= remaining - CNT_W'(dec);
    end
  end

endmodule

/* verilog/patch_pkg.sv */
package patch_pkg;

  // pixel, weight and column widths
  localparam int PIXEL_SIZE  = 12;
  localparam int WEIGHT_SIZE = 16;
  localparam int N_COL_SIZE  = 12;

  // pixels per camera beat
  localparam int N_LANES = 4;

  typedef logic [PIXEL_SIZE-1:0]  pixel_t;
  typedef logic [WEIGHT_SIZE-1:0] weight_t;
  typedef logic [N_COL_SIZE-1:0]  col_t;

  // camera-side matcher
  typedef enum logic [1:0] {
    CL_UNINITIALIZED,
    CL_WAIT,     // armed, looking for the start column
    CL_MATCHED,  // inside the patch
    CL_DONE
  } match_state_t;

  // reduction side
  typedef enum logic [1:0] {
    CONFIG_WAIT,
    DATA_WAIT,
    SUM_RDY
  } sum_state_t;

endpackage

/* verilog/patch_row_reducer.sv */
module patch_row_reducer
  import patch_pkg::*;
#(
  parameter int PATCH_SIZE     = 6,
  parameter int APP_DATA_WIDTH = 256,
  parameter int FIFO_DEPTH     = 4
) (
  input  logic                                                reset,
  input  logic                                                cl_clk,
  input  logic                                                init,
  input  logic [APP_DATA_WIDTH-1:0]                           config_data,
  input  logic                                                sum_ack,
  input  logic                                                pixel012_valid,
  input  logic                                                pixel3_valid,
  input  col_t                                                r_col,
  input  logic [47:0]                                         pixel_top,
  input  logic [47:0]                                         pixel_btm,
  output logic                                                sum_rdy,
  output logic [$clog2(PATCH_SIZE)+PIXEL_SIZE+WEIGHT_SIZE-1:0] sum
);

  localparam int CNT_W = $clog2(PATCH_SIZE + 1);

  col_t             start_col;
  logic             b_top;
  logic             cfg_load;
  logic             load;
  logic [2:0]       dec;
  logic [CNT_W-1:0] remaining;
  logic             pix_strobe;
  logic             pix_valid;
  pixel_t           pix;

  match_if mq ();

  row_match_fsm #(.PATCH_SIZE(PATCH_SIZE)) u_match (
    .reset, .cl_clk, .cfg_load, .start_col, .b_top,
    .pixel012_valid, .pixel3_valid, .r_col, .pixel_top, .pixel_btm,
    .remaining, .load, .dec, .mq(mq)
  );

  patch_counter #(.PATCH_SIZE(PATCH_SIZE)) u_count (
    .reset, .cl_clk, .load, .dec, .remaining
  );

  lane_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
    .reset, .cl_clk, .mq(mq), .pix_strobe, .pix_valid, .pix
  );

  weighted_accumulator #(
    .PATCH_SIZE(PATCH_SIZE),
    .APP_DATA_WIDTH(APP_DATA_WIDTH)
  ) u_acc (
    .reset, .cl_clk, .init, .config_data, .sum_ack,
    .pix_strobe, .pix_valid, .pix,
    .start_col, .b_top, .cfg_load, .sum_rdy, .sum
  );

endmodule

/* verilog/row_match_fsm.sv */
module row_match_fsm
  import patch_pkg::*;
#(
  parameter int PATCH_SIZE = 6
) (
  input  logic                            reset,
  input  logic                            cl_clk,
  input  logic                            cfg_load,
  input  col_t                            start_col,
  input  logic                            b_top,
  input  logic                            pixel012_valid,
  input  logic                            pixel3_valid,
  input  col_t                            r_col,
  input  logic [47:0]                     pixel_top,
  input  logic [47:0]                     pixel_btm,
  input  logic [$clog2(PATCH_SIZE+1)-1:0] remaining,
  output logic                            load,
  output logic [2:0]                      dec,
  match_if.src                            mq
);

  match_state_t       state;
  logic               beat;
  logic               matching;
  logic               writing;
  col_t               diff;
  logic [47:0]        row;
  logic [N_LANES-1:0] lane_raw;
  logic [N_LANES-1:0] lane_ok;
  logic [2:0]         taken;

  assign beat     = pixel012_valid | pixel3_valid;
  assign matching = (state == CL_WAIT) && beat && (r_col >= start_col);
  assign writing  = matching || ((state == CL_MATCHED) && beat);
  assign diff     = r_col - start_col;
  assign row      = b_top ? pixel_top : pixel_btm;

  // lane flags, then trimmed to the pixels still owed to the patch
  always_comb begin
    int back;
    back  = 0;
    taken = 3'd0;
    for (int i = 0; i < N_LANES; i++) begin
      back = (pixel3_valid ? N_LANES - 1 : N_LANES - 2) - i;  // columns left of r_col
      lane_raw[i] = writing && ((i < N_LANES - 1) || pixel3_valid)
                    && ((state == CL_MATCHED) || (diff >= col_t'(back)));
    end
    for (int i = 0; i < N_LANES; i++) begin
      lane_ok[i] = lane_raw[i] && (taken < remaining);
      taken      = taken + 3'(lane_ok[i]);
    end
  end

  always_comb begin
    for (int i = 0; i < N_LANES; i++) begin
      mq.lane_pixel[i] = row[(N_LANES-1-i)*PIXEL_SIZE +: PIXEL_SIZE];
    end
  end

  assign mq.wr_en      = writing;
  assign mq.lane_valid = lane_ok;
  assign dec           = taken;
  assign load          = cfg_load;  // counter restarts with the new config

  always_ff @(posedge reset or posedge cl_clk) begin
    if (cl_clk) begin
      state <= CL_UNINITIALIZED;
    end else if (cfg_load) begin
      state <= CL_WAIT;
    end else begin
      case (state)
        CL_WAIT: begin
          if (matching) begin
            state <= (taken >= remaining) ? CL_DONE : CL_MATCHED;
          end
        end
        CL_MATCHED: begin
          if (writing && (taken >= remaining)) begin
            state <= CL_DONE;
          end
        end
        default: begin
          state <= state;  // held until the next cfg_load
        end
      endcase
    end
  end

  // the counter never goes negative inside a patch
  a_dec_in_range: assert property (@(posedge reset) disable iff (cl_clk)
    (state == CL_MATCHED) |-> (dec <= remaining))
    else $error("row_match_fsm: dec %0d over remaining %0d", dec, remaining);

endmodule

/* verilog/weighted_accumulator.sv */
module weighted_accumulator
  import patch_pkg::*;
#(
  parameter int PATCH_SIZE     = 6,
  parameter int APP_DATA_WIDTH = 256
) (
  input  logic                                                reset,
  input  logic                                                cl_clk,
  input  logic                                                init,
  input  logic [APP_DATA_WIDTH-1:0]                           config_data,
  input  logic                                                sum_ack,
  input  logic                                                pix_strobe,
  input  logic                                                pix_valid,
  input  pixel_t                                              pix,
  output col_t                                                start_col,
  output logic                                                b_top,
  output logic                                                cfg_load,
  output logic                                                sum_rdy,
  output logic [$clog2(PATCH_SIZE)+PIXEL_SIZE+WEIGHT_SIZE-1:0] sum
);

  localparam int SUM_W     = $clog2(PATCH_SIZE) + PIXEL_SIZE + WEIGHT_SIZE;
  localparam int PAIR_W    = PIXEL_SIZE + WEIGHT_SIZE;  // weight low, dark high
  localparam int PAIR_BASE = 1 + N_COL_SIZE;
  localparam int IDX_W     = (PATCH_SIZE > 1) ? $clog2(PATCH_SIZE) : 1;

  sum_state_t                      state;
  pixel_t                          dark   [PATCH_SIZE];
  weight_t                         weight [PATCH_SIZE];
  logic [IDX_W-1:0]                k;  // pixels received so far
  pixel_t                          dark_sub;
  logic [PIXEL_SIZE+WEIGHT_SIZE-1:0] product;
  logic                            take_cfg;
  logic                            take_pix;

  assign take_cfg = (state == CONFIG_WAIT) && init;
  assign take_pix = (state == DATA_WAIT) && pix_strobe && pix_valid;
  assign dark_sub = pix - dark[k];  // wraps modulo 4096
  assign product  = dark_sub * weight[k];
  assign sum_rdy  = (state == SUM_RDY);

  always_ff @(posedge reset or posedge cl_clk) begin
    if (cl_clk) begin
      state    <= CONFIG_WAIT;
      cfg_load <= 1'b0;
      k        <= '0;
    end else begin
      cfg_load <= take_cfg;  // one cycle, lined up with DATA_WAIT entry
      case (state)
        CONFIG_WAIT: begin
          if (take_cfg) begin
            k     <= '0;
            state <= DATA_WAIT;
          end
        end
        DATA_WAIT: begin
          if (take_pix) begin
            if (k == IDX_W'(PATCH_SIZE - 1)) begin
              k     <= '0;  // keeps the weight index in range
              state <= SUM_RDY;
            end else begin
              k <= k + 1'b1;
            end
          end
        end
        SUM_RDY: begin
          if (sum_ack) begin
            state <= CONFIG_WAIT;
          end
        end
        default: begin
          state <= CONFIG_WAIT;
        end
      endcase
    end
  end

  // config unpack and the running sum
  always_ff @(posedge reset) begin
    if (take_cfg) begin
      b_top     <= config_data[0];
      start_col <= config_data[N_COL_SIZE:1];
      for (int c = 0; c < PATCH_SIZE; c++) begin
        weight[c] <= config_data[PAIR_BASE + c*PAIR_W +: WEIGHT_SIZE];
        dark[c]   <= config_data[PAIR_BASE + c*PAIR_W + WEIGHT_SIZE +: PIXEL_SIZE];
      end
      sum <= '0;
    end else if (take_pix) begin
      sum <= sum + SUM_W'(product);
    end
  end

  // the matcher sends exactly PATCH_SIZE valid lanes per config
  a_pix_in_window: assert property (@(posedge reset) disable iff (cl_clk)
    (pix_strobe && pix_valid) |-> (state == DATA_WAIT))
    else $error("weighted_accumulator: valid pixel in state %s", state.name());

endmodule
